//--- Bender.yml
package:
  name: command_processor

sources:
  - common/scope_cmd_pkg.sv
  - verilog/cmd_receiver.sv
  - verilog/setting_regs.sv
  - spi_seq/spi_sequencer.sv
  - verilog/resp_arbiter.sv
  - verilog/command_processor_top.sv
  - target: simulation
    files:
      - sim/tb_command_processor.sv

//--- command_processor.f
common/scope_cmd_pkg.sv
verilog/cmd_receiver.sv
verilog/setting_regs.sv
spi_seq/spi_sequencer.sv
verilog/resp_arbiter.sv
verilog/command_processor_top.sv
sim/tb_command_processor.sv

//--- common/scope_cmd_pkg.sv
// shared types for the command processor; cmd_t holds the first byte received in bits 7..0
package scope_cmd_pkg;

   localparam logic [31:0] FW_VERSION = 32'd26; // reported by info and readback
   localparam logic [3:0]  BEAT_KEEP  = 4'b1111; // every response beat is a full word

   // opcodes still served, unknown ones are dropped by the receiver
   typedef enum logic [7:0] {
      OP_ARM      = 8'd1,
      OP_INFO     = 8'd2,
      OP_SPI      = 8'd3,
      OP_SPI_MODE = 8'd4,
      OP_TRIG_SET = 8'd8,
      OP_DS_SET   = 8'd9,
      OP_READ_REG = 8'd14
   } opcode_e;

   typedef struct packed {
      logic [7:0] arg7; // spi byte count
      logic [7:0] arg6;
      logic [7:0] arg5;
      logic [7:0] arg4;
      logic [7:0] arg3;
      logic [7:0] arg2;
      logic [7:0] arg1;
      logic [7:0] opcode; // raw byte, may be unknown
   } cmd_t;

   typedef struct packed {
      logic        valid; // one-cycle result strobe
      logic [31:0] data;
   } unit_resp_t;

   typedef struct packed {
      logic signed [11:0] lower_thresh;
      logic signed [11:0] upper_thresh;
      logic [9:0]         ram_preoffset;
      logic [7:0]         trigger_tot;
      logic               trigger_chan;
      logic [7:0]         trigger_type;
      logic [7:0]         channel_type;
      logic [15:0]        length_to_take;
      logic               trigger_live;
      logic [4:0]         downsample;
      logic               highres;
      logic [7:0]         ds_merging;
   } trig_cfg_t;

   typedef struct packed {
      logic [7:0] tx_byte;
      logic       tx_dv;
      logic [7:0] cs_n; // active low
      logic [2:0] miso_sel;
      logic [1:0] mode;
      logic       reset_l;
   } spi_out_t;

   // mode and reset of the spi master, owned by the register unit
   typedef struct packed {
      logic [1:0] mode;
      logic       reset_l;
   } spi_cfg_t;

   function automatic logic is_known_op(input logic [7:0] op);
      case (op)
         OP_ARM, OP_INFO, OP_SPI, OP_SPI_MODE,
         OP_TRIG_SET, OP_DS_SET, OP_READ_REG: return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

endpackage

//--- sim/tb_command_processor.sv
// assumes one command in flight and an spi device that answers every byte; the run is bounded by a watchdog
`timescale 1ns/1ps
module tb_command_processor;

   localparam int          N_CMDS      = 80;
   localparam int          CYC_PER_CMD = 200; // also the per-wait timeout
   localparam logic [31:0] SEED        = 32'h7183_5468;
   localparam logic [31:0] VERSION     = 32'd26;

   logic        clk50 = 1'b0;
   logic        pllreset2;
   logic        i_tvalid;
   logic [7:0]  i_tdata;
   logic        o_tready;
   logic        o_tvalid;
   logic [31:0] o_tdata;
   logic [3:0]  o_tkeep;
   logic        o_tlast;
   logic        i_tready;
   logic        i_spi_tx_ready;
   logic        i_spi_rx_dv;
   logic [7:0]  i_spi_rx;
   logic [7:0]  i_acqstate;
   logic [19:0] i_sample_triggered;
   logic [31:0] i_eventcounter;
   logic [7:0]  i_boardin;
   scope_cmd_pkg::spi_out_t  o_spi;
   scope_cmd_pkg::trig_cfg_t o_trig;

   // reference model state
   logic [7:0]               m_acq;
   logic [19:0]              m_sample;
   logic [31:0]              m_evcnt;
   logic [7:0]               m_boardin;
   scope_cmd_pkg::trig_cfg_t m_trig;
   scope_cmd_pkg::spi_out_t  m_spi;

   logic [31:0] st_main  = SEED;
   logic [31:0] st_stall = SEED;
   logic [31:0] st_dev   = SEED;
   int          errors      = 0;
   int          mon_errors  = 0;
   int          beat_cnt    = 0;
   logic        hung        = 1'b0;
   logic        held        = 1'b0;
   logic [31:0] held_data;
   logic        dev_busy    = 1'b0;
   int          dev_wait    = 0;
   logic [7:0]  dev_byte;

   command_processor_top #(
      .CS_SETUP_CYCLES(10),
      .CS_HOLD_CYCLES (35)
   ) i_command_processor_top (.*);

   always #2 clk50 = ~clk50; // 4 ns period

   // x^32 + x^22 + x^2 + x + 1, one step per bit
   function automatic logic [31:0] lfsr_advance(input logic [31:0] s, input int n);
      logic [31:0] r;
      logic        fb;
      r = s;
      for (int i = 0; i < n; i++) begin
         fb = r[31] ^ r[21] ^ r[1] ^ r[0];
         r  = {r[30:0], fb};
      end
      return r;
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      st_main = lfsr_advance(st_main, n);
      v       = st_main & ~(32'hffff_ffff << n); // the n fresh bits
   endtask

   // (level -/+ hysteresis - 128) * 16 + 8, kept to 12 bits
   function automatic logic [11:0] thresh_code(input logic [7:0] lvl, input logic [7:0] hyst,
                                               input logic up);
      int v;
      v = up ? (int'(lvl) + int'(hyst) - 128) : (int'(lvl) - int'(hyst) - 128);
      v = v * 16 + 8;
      return v[11:0];
   endfunction

   function automatic string kind_name(input int k);
      case (k)
         0:       return "arm";
         1:       return "info";
         2:       return "spi transfer";
         3:       return "spi mode";
         4:       return "trigger settings";
         5:       return "downsample settings";
         6:       return "register readback";
         default: return "unknown opcode";
      endcase
   endfunction

   function automatic logic [31:0] expect_resp(input scope_cmd_pkg::cmd_t c);
      logic [31:0] r;
      r = 32'd0;
      case (c.opcode)
         scope_cmd_pkg::OP_ARM:      r = {4'd0, m_sample, m_acq};
         scope_cmd_pkg::OP_INFO: case (c.arg1)
            8'd0: r = VERSION;
            8'd1: r = {24'd0, m_boardin};
            8'd3: r = m_evcnt;
            default: r = 32'd0;
         endcase
         scope_cmd_pkg::OP_SPI: begin
            // last byte of each send group comes back xored
            r[15:8] = ((c.arg7 == 8'd2) ? c.arg2 : c.arg3) ^ 8'hA5;
            r[7:0]  = ((c.arg7 == 8'd4) ? c.arg5 : c.arg4) ^ 8'hA5;
         end
         scope_cmd_pkg::OP_SPI_MODE: r = {24'd0, c.arg1};
         scope_cmd_pkg::OP_TRIG_SET: r = 32'd8;
         scope_cmd_pkg::OP_DS_SET:   r = 32'd9;
         scope_cmd_pkg::OP_READ_REG: case (c.arg1)
            8'd0:  r = {22'd0, m_trig.ram_preoffset};
            8'd3:  r = VERSION;
            8'd4:  r = {24'd0, m_boardin};
            8'd5:  r = {24'd0, m_acq};
            8'd6:  r = m_evcnt;
            8'd9:  r = {24'd0, m_trig.ds_merging};
            8'd10: r = {27'd0, m_trig.downsample};
            8'd11: r = {31'd0, m_trig.highres};
            8'd12: r = {20'd0, m_trig.upper_thresh};
            default: r = 32'd0;
         endcase
         default: r = 32'd0;
      endcase
      return r;
   endfunction

   task automatic apply_model(input scope_cmd_pkg::cmd_t c, input logic known);
      if (known) m_trig.trigger_live = (c.opcode == scope_cmd_pkg::OP_ARM) && (m_acq == 8'd0);
      case (c.opcode)
         scope_cmd_pkg::OP_ARM: begin
            m_trig.trigger_type   = c.arg1;
            m_trig.channel_type   = c.arg2;
            m_trig.length_to_take = {c.arg5, c.arg4};
         end
         scope_cmd_pkg::OP_SPI:      m_spi.miso_sel = c.arg1[2:0];
         scope_cmd_pkg::OP_SPI_MODE: m_spi.mode = c.arg1[1:0];
         scope_cmd_pkg::OP_TRIG_SET: begin
            m_trig.lower_thresh  = thresh_code(c.arg1, c.arg2, 1'b0);
            m_trig.upper_thresh  = thresh_code(c.arg1, c.arg2, 1'b1);
            m_trig.ram_preoffset = {c.arg3[1:0], c.arg4};
            m_trig.trigger_tot   = c.arg5;
            m_trig.trigger_chan  = c.arg6[0];
         end
         scope_cmd_pkg::OP_DS_SET: begin
            m_trig.downsample = c.arg1[4:0];
            m_trig.highres    = c.arg2[0];
            m_trig.ds_merging = c.arg3;
         end
         default: ;
      endcase
   endtask

   task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp) begin
         $display("FAILED %s expected %h actual %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic check_trig(input string name, input scope_cmd_pkg::trig_cfg_t exp,
                             input scope_cmd_pkg::trig_cfg_t act);
      if (act !== exp) begin
         $display("FAILED %s trig_cfg expected %h actual %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic check_spi(input string name, input scope_cmd_pkg::spi_out_t exp,
                            input scope_cmd_pkg::spi_out_t act);
      scope_cmd_pkg::spi_out_t e;
      scope_cmd_pkg::spi_out_t a;
      e         = exp;
      a         = act;
      e.tx_byte = 8'd0; // tx byte only means something while tx_dv is high
      a.tx_byte = 8'd0;
      if (a !== e) begin
         $display("FAILED %s spi_out expected %h actual %h", name, e, a);
         errors++;
      end
   endtask

   task automatic send_cmd(input string name, input scope_cmd_pkg::cmd_t c);
      int n;
      for (int i = 0; i < 8 && !hung; i++) begin
         i_tvalid <= 1'b1;
         i_tdata  <= c[8*i +: 8];
         n = 0;
         do begin
            @(posedge clk50);
            n++;
         end while (!o_tready && n < CYC_PER_CMD);
         if (!o_tready) begin
            $display("%s: command byte %0d was never accepted", name, i);
            errors++;
            hung = 1'b1;
         end
      end
      i_tvalid <= 1'b0;
   endtask

   // also watches the chip selects until the beat is taken
   task automatic wait_beat(input string name, input logic is_spi, input logic [2:0] sel,
                            output logic [31:0] data);
      int         n;
      logic       low_seen;
      logic       cs_err;
      logic [7:0] cs_ok;
      n        = 0;
      low_seen = 1'b0;
      cs_err   = 1'b0;
      cs_ok    = ~(8'h01 << sel);
      data     = 32'd0;
      do begin
         @(posedge clk50);
         n++;
         if (o_spi.cs_n !== 8'hff) begin
            low_seen = 1'b1;
            if ((!is_spi || o_spi.cs_n !== cs_ok) && !cs_err) begin
               $display("%s: chip selects %b low outside the requested line", name, o_spi.cs_n);
               errors++;
               cs_err = 1'b1;
            end
         end
         if (o_tvalid && o_spi.cs_n !== 8'hff && !cs_err) begin
            $display("%s: response came while a chip select was still low", name);
            errors++;
            cs_err = 1'b1;
         end
      end while (!(o_tvalid && i_tready) && n < CYC_PER_CMD);
      if (o_tvalid && i_tready) data = o_tdata;
      else begin
         $display("%s: no response beat within %0d cycles", name, CYC_PER_CMD);
         errors++;
         hung = 1'b1;
      end
      if (is_spi && !low_seen) begin
         $display("%s: chip select never went low", name);
         errors++;
      end
   endtask

   // random back-pressure, ready three times in four
   always @(posedge clk50) begin
      st_stall = lfsr_advance(st_stall, 2);
      i_tready <= (st_stall[1:0] != 2'd0);
   end

   // spi device, busy from a tx strobe until it answers
   always @(posedge clk50) begin
      i_spi_rx_dv <= 1'b0;
      if (pllreset2) begin
         dev_busy = 1'b0;
         i_spi_tx_ready <= 1'b1;
      end else if (dev_busy) begin
         if (dev_wait == 0) begin
            i_spi_rx_dv    <= 1'b1;
            i_spi_rx       <= dev_byte ^ 8'hA5;
            i_spi_tx_ready <= 1'b1;
            dev_busy = 1'b0;
         end else dev_wait--;
      end else if (o_spi.tx_dv) begin
         dev_byte = o_spi.tx_byte;
         st_dev   = lfsr_advance(st_dev, 3);
         dev_wait = st_dev[2:0]; // answer 1 to 8 cycles later
         dev_busy = 1'b1;
         i_spi_tx_ready <= 1'b0;
      end
   end

   // beat monitor on the response stream
   always @(posedge clk50) begin
      int add;
      add = 0;
      if (!pllreset2) begin
         if (o_tvalid && i_tready) begin
            beat_cnt <= beat_cnt + 1;
            if (o_tkeep !== 4'b1111 || o_tlast !== 1'b1) begin
               $display("FAILED beat framing expected keep f last 1 actual keep %h last %b",
                        o_tkeep, o_tlast);
               add++;
            end
         end
         if (held && !o_tvalid) begin
            $display("response valid dropped before the beat was taken");
            add++;
         end
         if (held && o_tdata !== held_data) begin
            $display("FAILED stalled beat data expected %h actual %h", held_data, o_tdata);
            add++;
         end
      end
      held      <= !pllreset2 && o_tvalid && !i_tready;
      held_data <= o_tdata;
      mon_errors <= mon_errors + add;
   end

   initial begin
      repeat (N_CMDS * CYC_PER_CMD) @(posedge clk50);
      $display("watchdog expired after %0d cycles without finishing", N_CMDS * CYC_PER_CMD);
      $display("Simulation finished: FAIL");
      $finish;
   end

   initial begin : main
      scope_cmd_pkg::cmd_t c;
      logic [31:0]         r;
      logic [31:0]         got;
      logic [31:0]         exp_word;
      int                  kind;
      int                  exp_beats;
      int                  err_before;
      int                  failed_tests;
      string               name;
      pllreset2          = 1'b1;
      i_tvalid           = 1'b0;
      i_tdata            = 8'd0;
      i_tready           = 1'b0;
      i_spi_tx_ready     = 1'b1;
      i_spi_rx_dv        = 1'b0;
      i_spi_rx           = 8'd0;
      i_acqstate         = 8'd0;
      i_sample_triggered = 20'd0;
      i_eventcounter     = 32'd0;
      i_boardin          = 8'd0;
      exp_beats          = 0;
      failed_tests       = 0;
      m_trig = '0;
      m_spi  = '{tx_byte: 8'd0, tx_dv: 1'b0, cs_n: 8'hff, miso_sel: 3'd0, mode: 2'd0,
                 reset_l: 1'b1};
      repeat (4) @(posedge clk50);
      pllreset2 <= 1'b0;
      @(posedge clk50);
      check_word("reset tready", 32'd1, {31'd0, o_tready});
      check_word("reset tvalid", 32'd0, {31'd0, o_tvalid});
      check_trig("reset", m_trig, o_trig);
      check_spi("reset", m_spi, o_spi);
      $display("reset state: %s", (errors == 0) ? "ok" : "wrong");

      for (int t = 0; t < N_CMDS && !hung; t++) begin
         err_before = errors + mon_errors;
         take_bits(1, r);
         take_bits(8, got);
         m_acq = r[0] ? 8'd0 : got[7:0]; // zero half of the time
         take_bits(20, r);
         m_sample = r[19:0];
         take_bits(16, r);
         take_bits(16, got);
         m_evcnt = {r[15:0], got[15:0]};
         take_bits(8, r);
         m_boardin = r[7:0];
         i_acqstate         <= m_acq;
         i_sample_triggered <= m_sample;
         i_eventcounter     <= m_evcnt;
         i_boardin          <= m_boardin;

         take_bits(3, r);
         kind = int'(r[2:0]);
         c    = '0;
         for (int b = 1; b < 8; b++) begin
            take_bits(8, r);
            c[8*b +: 8] = r[7:0];
         end
         case (kind)
            0: c.opcode = scope_cmd_pkg::OP_ARM;
            1: begin
               c.opcode = scope_cmd_pkg::OP_INFO;
               c.arg1   = {5'd0, c.arg1[2:0]}; // codes 0 to 7
            end
            2: begin
               c.opcode = scope_cmd_pkg::OP_SPI;
               take_bits(2, r);
               c.arg7 = 8'd2 + (r[1:0] % 3); // 2 to 4 bytes
            end
            3: c.opcode = scope_cmd_pkg::OP_SPI_MODE;
            4: c.opcode = scope_cmd_pkg::OP_TRIG_SET;
            5: c.opcode = scope_cmd_pkg::OP_DS_SET;
            6: begin
               c.opcode = scope_cmd_pkg::OP_READ_REG;
               c.arg1   = {4'd0, c.arg1[3:0]};
            end
            default: c.opcode = {1'b1, c.arg6[6:0]}; // never a known opcode
         endcase
         name     = $sformatf("test %0d %s", t, kind_name(kind));
         exp_word = expect_resp(c);

         send_cmd(name, c);
         if (!hung) begin
            if (kind == 7) begin
               repeat (30) @(posedge clk50);
            end else begin
               wait_beat(name, kind == 2, c.arg1[2:0], got);
               if (!hung) check_word(name, exp_word, got);
               exp_beats++;
               @(posedge clk50);
            end
         end
         if (!hung) begin
            apply_model(c, kind != 7);
            check_word({name, " beat count"}, exp_beats, beat_cnt);
            check_trig(name, m_trig, o_trig);
            check_spi(name, m_spi, o_spi);
         end
         if (errors + mon_errors == err_before) $display("%s: ok", name);
         else begin
            failed_tests++;
            $display("%s: %0d errors", name, errors + mon_errors - err_before);
         end
      end

      repeat (2) @(posedge clk50);
      $display("tests run %0d, tests with errors %0d, total errors %0d",
               N_CMDS, failed_tests, errors + mon_errors);
      if (errors + mon_errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

//--- spi_seq/spi_sequencer.sv
// expects an spi master that drops tx ready for a byte and gives one rx strobe per byte sent
`timescale 1ns/1ps
module spi_sequencer #(
   parameter int CS_SETUP_CYCLES = 10,
   parameter int CS_HOLD_CYCLES  = 35
) (
   input  logic                      clk50,
   input  logic                      pllreset2,
   input  scope_cmd_pkg::cmd_t       i_cmd,
   input  logic                      i_dispatch,
   input  scope_cmd_pkg::spi_cfg_t   i_spi_cfg,
   input  logic                      i_spi_tx_ready,
   input  logic                      i_spi_rx_dv,
   input  logic [7:0]                i_spi_rx,
   output scope_cmd_pkg::spi_out_t   o_spi,
   output scope_cmd_pkg::unit_resp_t o_resp
);

   localparam int CNT_MAX = (CS_SETUP_CYCLES > CS_HOLD_CYCLES) ? CS_SETUP_CYCLES : CS_HOLD_CYCLES;
   localparam int CNT_W   = $clog2(CNT_MAX + 1);

   typedef enum logic [3:0] {
      ST_IDLE, ST_SETUP, ST_SEND_A, ST_SEND_B, ST_RX_HI,
      ST_SEND_C, ST_SEND_D, ST_RX_LO, ST_HOLD
   } spi_state_e;

   spi_state_e       state;
   logic [CNT_W-1:0] cnt;
   logic [7:0]       tx_q;
   logic             tx_dv_q;
   logic [7:0]       cs_n_q;
   logic [2:0]       miso_sel_q;
   logic [7:0]       rx_hi_q;
   logic [7:0]       rx_lo_q;
   logic             resp_valid_q;
   logic             can_send;

   assign can_send = i_spi_tx_ready && !tx_dv_q; // ready may lag the strobe by a cycle

   always_ff @(posedge clk50) begin
      if (pllreset2) begin
         state        <= ST_IDLE;
         cnt          <= '0;
         tx_dv_q      <= 1'b0;
         cs_n_q       <= 8'hff;
         miso_sel_q   <= 3'd0;
         resp_valid_q <= 1'b0;
      end else begin
         tx_dv_q      <= 1'b0;
         resp_valid_q <= 1'b0;
         case (state)
            ST_IDLE: if (i_dispatch && i_cmd.opcode == scope_cmd_pkg::OP_SPI) begin
               cs_n_q[i_cmd.arg1[2:0]] <= 1'b0;
               miso_sel_q              <= i_cmd.arg1[2:0];
               cnt                     <= '0;
               state                   <= ST_SETUP;
            end
            ST_SETUP: if (cnt == CNT_W'(CS_SETUP_CYCLES - 1)) begin
               tx_q  <= i_cmd.arg2;
               state <= ST_SEND_A;
            end else cnt <= cnt + 1'b1;
            ST_SEND_A: if (can_send) begin
               tx_dv_q <= 1'b1;
               state   <= (i_cmd.arg7 == 8'd2) ? ST_RX_HI : ST_SEND_B;
            end
            ST_SEND_B: if (tx_dv_q) tx_q <= i_cmd.arg3; // load after the strobe
            else if (can_send) begin
               tx_dv_q <= 1'b1;
               state   <= ST_RX_HI;
            end
            ST_RX_HI: if (i_spi_rx_dv) begin
               rx_hi_q <= i_spi_rx;
               tx_q    <= i_cmd.arg4;
               state   <= ST_SEND_C;
            end
            ST_SEND_C: if (can_send) begin
               tx_dv_q <= 1'b1;
               state   <= (i_cmd.arg7 == 8'd4) ? ST_SEND_D : ST_RX_LO;
            end
            ST_SEND_D: if (tx_dv_q) tx_q <= i_cmd.arg5;
            else if (can_send) begin
               tx_dv_q <= 1'b1;
               state   <= ST_RX_LO;
            end
            ST_RX_LO: if (i_spi_rx_dv) begin
               rx_lo_q <= i_spi_rx;
               cnt     <= '0;
               state   <= ST_HOLD;
            end
            ST_HOLD: if (cnt == CNT_W'(CS_HOLD_CYCLES - 1)) begin
               cs_n_q       <= 8'hff; // deselect before reporting
               resp_valid_q <= 1'b1;
               state        <= ST_IDLE;
            end else cnt <= cnt + 1'b1;
            default: state <= ST_IDLE;
         endcase
      end
   end

   assign o_spi = '{tx_byte: tx_q, tx_dv: tx_dv_q, cs_n: cs_n_q, miso_sel: miso_sel_q,
                    mode: i_spi_cfg.mode, reset_l: i_spi_cfg.reset_l};
   assign o_resp = '{valid: resp_valid_q, data: {16'd0, rx_hi_q, rx_lo_q}};

   // each rx strobe must answer a byte already sent
   a_rx_only_when_waiting: assert property (@(posedge clk50) disable iff (pllreset2)
      i_spi_rx_dv |-> state inside {ST_SEND_B, ST_RX_HI, ST_SEND_D, ST_RX_LO});

endmodule

//--- verilog/cmd_receiver.sv
// commands are exactly 8 bytes with no framing, so a lost or extra byte shifts all later commands
`timescale 1ns/1ps
module cmd_receiver (
   input  logic                clk50,
   input  logic                pllreset2,
   input  logic                i_tvalid,
   input  logic [7:0]          i_tdata,
   output logic                o_tready,
   input  logic                i_done,
   output scope_cmd_pkg::cmd_t o_cmd,
   output logic                o_dispatch
);

   typedef enum logic [1:0] {
      ST_RX,   // collecting bytes
      ST_SKIP, // unknown opcode, one idle cycle
      ST_BUSY  // waiting for the response to leave
   } rx_state_e;

   rx_state_e  state;
   logic [2:0] byte_cnt;
   logic       byte_acc;
   logic       last_byte;

   assign o_tready  = (state == ST_RX);
   assign byte_acc  = i_tvalid && o_tready;
   assign last_byte = byte_acc && (byte_cnt == 3'd7);

   always_ff @(posedge clk50) begin
      if (pllreset2) begin
         state      <= ST_RX;
         byte_cnt   <= 3'd0;
         o_dispatch <= 1'b0;
      end else begin
         o_dispatch <= last_byte && scope_cmd_pkg::is_known_op(o_cmd.opcode);
         if (byte_acc) byte_cnt <= byte_cnt + 3'd1; // wraps after byte 7
         case (state)
            ST_RX: if (last_byte) begin
               state <= scope_cmd_pkg::is_known_op(o_cmd.opcode) ? ST_BUSY : ST_SKIP;
            end
            ST_SKIP: state <= ST_RX;
            ST_BUSY: if (i_done) state <= ST_RX;
            default: state <= ST_RX;
         endcase
      end
   end

   // byte n lands in bits 8n+7..8n, opcode first
   always_ff @(posedge clk50) begin
      if (byte_acc) o_cmd[{byte_cnt, 3'b000} +: 8] <= i_tdata;
   end

   // done may only close a dispatched command
   a_done_while_busy: assert property (@(posedge clk50) disable iff (pllreset2)
      i_done |-> state == ST_BUSY);

endmodule

//--- verilog/command_processor_top.sv
// chip-select timing is in clk50 cycles and sized for the slowest spi device on the board
`timescale 1ns/1ps
module command_processor_top #(
   parameter int CS_SETUP_CYCLES = 10,
   parameter int CS_HOLD_CYCLES  = 35
) (
   input  logic                     clk50,
   input  logic                     pllreset2,
   input  logic                     i_tvalid,
   input  logic [7:0]               i_tdata,
   output logic                     o_tready,
   output logic                     o_tvalid,
   output logic [31:0]              o_tdata,
   output logic [3:0]               o_tkeep,
   output logic                     o_tlast,
   input  logic                     i_tready,
   input  logic                     i_spi_tx_ready,
   input  logic                     i_spi_rx_dv,
   input  logic [7:0]               i_spi_rx,
   output scope_cmd_pkg::spi_out_t  o_spi,
   output scope_cmd_pkg::trig_cfg_t o_trig,
   input  logic [7:0]               i_acqstate,
   input  logic [19:0]              i_sample_triggered,
   input  logic [31:0]              i_eventcounter,
   input  logic [7:0]               i_boardin
);

   scope_cmd_pkg::cmd_t       cmd;
   scope_cmd_pkg::unit_resp_t reg_resp;
   scope_cmd_pkg::unit_resp_t spi_resp;
   scope_cmd_pkg::spi_cfg_t   spi_cfg;
   logic                      dispatch;
   logic                      done;

   cmd_receiver i_cmd_receiver (
      .clk50, .pllreset2, .i_tvalid, .i_tdata, .o_tready,
      .i_done(done), .o_cmd(cmd), .o_dispatch(dispatch)
   );

   setting_regs i_setting_regs (
      .clk50, .pllreset2, .i_cmd(cmd), .i_dispatch(dispatch),
      .i_acqstate, .i_sample_triggered, .i_eventcounter, .i_boardin,
      .o_trig, .o_spi_cfg(spi_cfg), .o_resp(reg_resp)
   );

   spi_sequencer #(
      .CS_SETUP_CYCLES(CS_SETUP_CYCLES),
      .CS_HOLD_CYCLES (CS_HOLD_CYCLES)
   ) i_spi_sequencer (
      .clk50, .pllreset2, .i_cmd(cmd), .i_dispatch(dispatch), .i_spi_cfg(spi_cfg),
      .i_spi_tx_ready, .i_spi_rx_dv, .i_spi_rx, .o_spi, .o_resp(spi_resp)
   );

   resp_arbiter i_resp_arbiter (
      .clk50, .pllreset2, .i_reg_resp(reg_resp), .i_spi_resp(spi_resp),
      .o_tvalid, .i_tready, .o_tdata, .o_tkeep, .o_tlast, .o_done(done)
   );

endmodule

//--- verilog/resp_arbiter.sv
// one command in flight is assumed, so a result arriving while a beat is stalled would be lost
`timescale 1ns/1ps
module resp_arbiter (
   input  logic                      clk50,
   input  logic                      pllreset2,
   input  scope_cmd_pkg::unit_resp_t i_reg_resp,
   input  scope_cmd_pkg::unit_resp_t i_spi_resp,
   output logic                      o_tvalid,
   input  logic                      i_tready,
   output logic [31:0]               o_tdata,
   output logic [3:0]                o_tkeep,
   output logic                      o_tlast,
   output logic                      o_done
);

   scope_cmd_pkg::unit_resp_t grant;
   logic                      beat_acc;
   logic                      load;

   assign grant    = i_reg_resp.valid ? i_reg_resp : i_spi_resp; // register unit first
   assign beat_acc = o_tvalid && i_tready;
   assign load     = grant.valid && (!o_tvalid || i_tready);

   always_ff @(posedge clk50) begin
      if (pllreset2) begin
         o_tvalid <= 1'b0;
         o_done   <= 1'b0;
      end else begin
         o_done <= beat_acc; // lets the receiver take the next command
         if (load) o_tvalid <= 1'b1;
         else if (beat_acc) o_tvalid <= 1'b0;
      end
   end

   always_ff @(posedge clk50) begin
      if (load) o_tdata <= grant.data;
   end

   assign o_tkeep = scope_cmd_pkg::BEAT_KEEP;
   assign o_tlast = 1'b1; // single-beat packets

   // a new result must not land on a stalled beat
   a_no_lost_result: assert property (@(posedge clk50) disable iff (pllreset2)
      grant.valid |-> !(o_tvalid && !i_tready));

   // both units never answer the same command
   a_one_result: assert property (@(posedge clk50) disable iff (pllreset2)
      !(i_reg_resp.valid && i_spi_resp.valid));

endmodule

//--- verilog/setting_regs.sv
// status inputs get one register stage only, so they must already be stable in clk50's domain
`timescale 1ns/1ps
module setting_regs (
   input  logic                      clk50,
   input  logic                      pllreset2,
   input  scope_cmd_pkg::cmd_t       i_cmd,
   input  logic                      i_dispatch,
   input  logic [7:0]                i_acqstate,
   input  logic [19:0]               i_sample_triggered,
   input  logic [31:0]               i_eventcounter,
   input  logic [7:0]                i_boardin,
   output scope_cmd_pkg::trig_cfg_t  o_trig,
   output scope_cmd_pkg::spi_cfg_t   o_spi_cfg,
   output scope_cmd_pkg::unit_resp_t o_resp
);

   logic [7:0]  acq_s;
   logic [19:0] sample_s;
   logic [31:0] evcnt_s;
   logic [7:0]  boardin_s;
   logic [11:0] level_ext;
   logic [11:0] hyst_ext;
   logic [11:0] lower_d;
   logic [11:0] upper_d;
   logic [31:0] resp_d;
   logic        mine;

   always_ff @(posedge clk50) begin
      acq_s     <= i_acqstate;
      sample_s  <= i_sample_triggered;
      evcnt_s   <= i_eventcounter;
      boardin_s <= i_boardin;
   end

   // threshold math wraps at 12 bits like the adc codes
   assign level_ext = {4'd0, i_cmd.arg1};
   assign hyst_ext  = {4'd0, i_cmd.arg2};
   assign lower_d   = ((level_ext - hyst_ext - 12'd128) << 4) + 12'd8;
   assign upper_d   = ((level_ext + hyst_ext - 12'd128) << 4) + 12'd8;

   assign mine = scope_cmd_pkg::is_known_op(i_cmd.opcode) && (i_cmd.opcode != scope_cmd_pkg::OP_SPI);

   always_comb begin
      resp_d = 32'd0;
      case (i_cmd.opcode)
         scope_cmd_pkg::OP_ARM:      resp_d = {4'd0, sample_s, acq_s};
         scope_cmd_pkg::OP_SPI_MODE: resp_d = {24'd0, i_cmd.arg1};
         scope_cmd_pkg::OP_TRIG_SET: resp_d = 32'd8;
         scope_cmd_pkg::OP_DS_SET:   resp_d = 32'd9;
         scope_cmd_pkg::OP_INFO: case (i_cmd.arg1)
            8'd0:    resp_d = scope_cmd_pkg::FW_VERSION;
            8'd1:    resp_d = {24'd0, boardin_s};
            8'd3:    resp_d = evcnt_s;
            default: resp_d = 32'd0;
         endcase
         scope_cmd_pkg::OP_READ_REG: case (i_cmd.arg1)
            8'd0:    resp_d = {22'd0, o_trig.ram_preoffset};
            8'd3:    resp_d = scope_cmd_pkg::FW_VERSION;
            8'd4:    resp_d = {24'd0, boardin_s};
            8'd5:    resp_d = {24'd0, acq_s};
            8'd6:    resp_d = evcnt_s;
            8'd9:    resp_d = {24'd0, o_trig.ds_merging};
            8'd10:   resp_d = {27'd0, o_trig.downsample};
            8'd11:   resp_d = {31'd0, o_trig.highres};
            8'd12:   resp_d = {20'd0, o_trig.upper_thresh}; // zero-extended
            default: resp_d = 32'd0;
         endcase
         default: resp_d = 32'd0;
      endcase
   end

   always_ff @(posedge clk50) begin
      if (pllreset2) begin
         o_trig       <= '0;
         o_spi_cfg    <= '{mode: 2'd0, reset_l: 1'b1};
         o_resp.valid <= 1'b0;
      end else begin
         o_resp.valid      <= i_dispatch && mine;
         o_spi_cfg.reset_l <= !(i_dispatch && i_cmd.opcode == scope_cmd_pkg::OP_SPI_MODE); // pulse
         if (i_dispatch) begin
            o_trig.trigger_live <= (i_cmd.opcode == scope_cmd_pkg::OP_ARM) && (acq_s == 8'd0);
            case (i_cmd.opcode)
               scope_cmd_pkg::OP_ARM: begin
                  o_trig.trigger_type   <= i_cmd.arg1;
                  o_trig.channel_type   <= i_cmd.arg2;
                  o_trig.length_to_take <= {i_cmd.arg5, i_cmd.arg4};
               end
               scope_cmd_pkg::OP_TRIG_SET: begin
                  o_trig.lower_thresh  <= $signed(lower_d);
                  o_trig.upper_thresh  <= $signed(upper_d);
                  o_trig.ram_preoffset <= {i_cmd.arg3[1:0], i_cmd.arg4};
                  o_trig.trigger_tot   <= i_cmd.arg5;
                  o_trig.trigger_chan  <= i_cmd.arg6[0];
               end
               scope_cmd_pkg::OP_DS_SET: begin
                  o_trig.downsample <= i_cmd.arg1[4:0];
                  o_trig.highres    <= i_cmd.arg2[0];
                  o_trig.ds_merging <= i_cmd.arg3;
               end
               scope_cmd_pkg::OP_SPI_MODE: o_spi_cfg.mode <= i_cmd.arg1[1:0];
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge clk50) begin
      if (i_dispatch) o_resp.data <= resp_d;
   end

endmodule
